/* dv/l2l1_sva.sv */
`default_nettype none

module l2l1_sva #(
	// ports seen by this instance
	parameter int PORTS = 2
) (
	input logic             clock_bus_i,
	input logic             reset_i,
	// bit n belongs to port n
	input logic [PORTS-1:0] grant_i,
	input logic [PORTS-1:0] rw_i,
	input logic [PORTS-1:0] tx_avail_i,
	input logic [PORTS-1:0] rx_space_i,
	input logic [PORTS-1:0] rx_push_i
);

	// failed assertions so far
	int fail_cnt = 0;

	// ------------------------------------------------------------------------
	// arbitration
	// ------------------------------------------------------------------------
	if (PORTS > 1) begin : g_shared
		a_one_grant: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
			$onehot0(grant_i))
		else begin
			$error("more than one grant in a cycle");
			fail_cnt++;
		end
	end

	for (genvar g = 0; g < PORTS; g++) begin : g_port
		// write grant needs a tx word
		a_wr_tx: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
			grant_i[g] && rw_i[g] |-> tx_avail_i[g])
		else begin
			$error("write grant without tx data on port %0d", g);
			fail_cnt++;
		end

		// read grant needs rx room
		a_rd_rx: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
			grant_i[g] && !rw_i[g] |-> rx_space_i[g])
		else begin
			$error("read grant without rx space on port %0d", g);
			fail_cnt++;
		end

		// read data lands two cycles after the grant
		a_rd_push: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
			grant_i[g] && !rw_i[g] |-> ##2 rx_push_i[g])
		else begin
			$error("rx_push missing two cycles after read grant on port %0d", g);
			fail_cnt++;
		end
	end

endmodule

// arbiter sees both ports
bind l2_arbiter l2l1_sva arb_sva_inst (
	.clock_bus_i(clock_bus_i),
	.reset_i    (reset_i),
	.grant_i    ({p1.grant, p0.grant}),
	.rw_i       ({p1.req_rw, p0.req_rw}),
	.tx_avail_i ({p1.tx_avail, p0.tx_avail}),
	.rx_space_i ({p1.rx_space, p0.rx_space}),
	.rx_push_i  ({p1.rx_push, p0.rx_push})
);

// each buffer checks its own port view
bind txrx_buffer l2l1_sva #(.PORTS(1)) buf_sva_inst (
	.clock_bus_i(clock_bus_i),
	.reset_i    (reset_i),
	.grant_i    (port.grant),
	.rw_i       (port.req_rw),
	.tx_avail_i (port.tx_avail),
	.rx_space_i (port.rx_space),
	.rx_push_i  (port.rx_push)
);

`default_nettype wire

/* dv/l2l1_tb.sv */
`default_nettype none

`include "l2l1_params.svh"

module l2l1_tb import l2l1_pkg::*; ();

	localparam int DEPTH      = `L2L1_BUF_DEPTH;
	localparam int WAIT_LIMIT = 200;
	localparam int LVL_REQ    = 0;
	localparam int LVL_WRITE  = 1;
	localparam int LVL_READ   = 2;
	// fixed upper address bits, only the low byte varies
	localparam logic [15:0] ADDR_HI = 16'h00c3;

	logic  clock_bus;
	logic  reset;
	logic  req [2];
	logic  rw [2];
	addr_t addr [2];
	logic  write_en [2];
	data_t wdata [2];
	logic  read_ack [2];
	logic  ready_req [2];
	logic  ready_write [2];
	logic  ready_read [2];
	data_t rdata [2];
	exc_t  exc [2];

	// model state
	data_t model_mem [store_addr_t];
	data_t tx_q [2][$];
	data_t rx_exp [2][$];
	exc_t  exc_exp [2];
	bit    used_addr [256];
	addr_t wr_addr [2][$];
	data_t wr_data [2][$];
	logic [15:0] lfsr_q;

	l2l1_top l2l1_top_inst (
		.clock_bus_i    (clock_bus),
		.reset_i        (reset),
		.req_0_i        (req[0]),
		.rw_0_i         (rw[0]),
		.addr_0_i       (addr[0]),
		.write_en_0_i   (write_en[0]),
		.data_0_i       (wdata[0]),
		.read_ack_0_i   (read_ack[0]),
		.ready_req_0_o  (ready_req[0]),
		.ready_write_0_o(ready_write[0]),
		.ready_read_0_o (ready_read[0]),
		.data_0_o       (rdata[0]),
		.exception_0_o  (exc[0]),
		.req_1_i        (req[1]),
		.rw_1_i         (rw[1]),
		.addr_1_i       (addr[1]),
		.write_en_1_i   (write_en[1]),
		.data_1_i       (wdata[1]),
		.read_ack_1_i   (read_ack[1]),
		.ready_req_1_o  (ready_req[1]),
		.ready_write_1_o(ready_write[1]),
		.ready_read_1_o (ready_read[1]),
		.data_1_o       (rdata[1]),
		.exception_1_o  (exc[1])
	);

	always #10 clock_bus = ~clock_bus;

	// ------------------------------------------------------------------------
	// reference model and random source
	// ------------------------------------------------------------------------

	// store only sees the low address byte
	function automatic data_t ref_read(input addr_t a);
		return model_mem[a[`L2L1_STORE_AW-1:0]];
	endfunction

	// galois lfsr, x^16+x^14+x^13+x^11+1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hb400;
		end
		return s >> 1;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// unused store word, probe upward on a hit
	function automatic addr_t fresh_addr();
		store_addr_t a;
		a = store_addr_t'(rand_bits(8));
		while (used_addr[a]) begin
			a = a + 1'b1;
		end
		used_addr[a] = 1'b1;
		return {ADDR_HI, a};
	endfunction

	function automatic logic level_of(input int p, input int kind);
		case (kind)
			LVL_REQ:   return ready_req[p];
			LVL_WRITE: return ready_write[p];
			default:   return ready_read[p];
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	task automatic stop_on_fail();
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
			stop_on_fail();
		end
	endtask

	task automatic check_exc(input exc_t got, input exc_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
			stop_on_fail();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
			stop_on_fail();
		end
	endtask

	// called at a falling edge, returns at a falling edge
	task automatic wait_high(input int p, input int kind, input string what);
		int n;
		n = 0;
		while (!level_of(p, kind)) begin
			if (n == WAIT_LIMIT) begin
				$display("timeout: %s on port %0d stayed low for %0d cycles",
					what, p, WAIT_LIMIT);
				stop_on_fail();
			end
			n++;
			@(negedge clock_bus);
		end
	endtask

	// ------------------------------------------------------------------------
	// drivers, each a one-cycle pulse from falling edge to falling edge
	// ------------------------------------------------------------------------
	task automatic pulse_write(input int p, input data_t d);
		// full tx drops the word
		if (tx_q[p].size() < DEPTH) begin
			tx_q[p].push_back(d);
		end else begin
			exc_exp[p][`L2L1_EXC_TX_OVF] = 1'b1;
		end
		write_en[p] = 1'b1;
		wdata[p]    = d;
		@(negedge clock_bus);
		write_en[p] = 1'b0;
	endtask

	task automatic pulse_req(input int p, input logic w, input addr_t a);
		req[p]  = 1'b1;
		rw[p]   = w;
		addr[p] = a;
		@(negedge clock_bus);
		req[p]  = 1'b0;
	endtask

	task automatic pulse_ack(input int p);
		if (rx_exp[p].size() == 0) begin
			exc_exp[p][`L2L1_EXC_RX_UDF] = 1'b1;
		end
		read_ack[p] = 1'b1;
		@(negedge clock_bus);
		read_ack[p] = 1'b0;
	endtask

	task automatic push_word(input int p, input data_t d);
		wait_high(p, LVL_WRITE, "ready_write");
		pulse_write(p, d);
	endtask

	// model follows issue order, a port serves its own requests in order
	task automatic issue_req(input int p, input logic w, input addr_t a);
		wait_high(p, LVL_REQ, "ready_req");
		if (w) begin
			model_mem[a[`L2L1_STORE_AW-1:0]] = tx_q[p].pop_front();
		end else begin
			rx_exp[p].push_back(ref_read(a));
		end
		pulse_req(p, w, a);
	endtask

	task automatic ack_word(input int p);
		wait_high(p, LVL_READ, "ready_read");
		pulse_ack(p);
	endtask

	task automatic read_back(input int p, input addr_t a);
		issue_req(p, 1'b0, a);
		ack_word(p);
	endtask

	task automatic write_burst(input int p);
		int i;
		for (i = 0; i < wr_addr[p].size(); i++) begin
			push_word(p, wr_data[p][i]);
			issue_req(p, 1'b1, wr_addr[p][i]);
		end
	endtask

	// port p reads the words that port q wrote
	task automatic cross_read(input int p, input int q);
		int i;
		for (i = 0; i < wr_addr[q].size(); i++) begin
			issue_req(p, 1'b0, wr_addr[q][i]);
		end
		repeat (wr_addr[q].size()) ack_word(p);
	endtask

	// ------------------------------------------------------------------------
	// compare process, rx head checked on each accepted read_ack
	// ------------------------------------------------------------------------
	always @(posedge clock_bus) begin
		for (int p = 0; p < 2; p++) begin
			if (reset && read_ack[p] && ready_read[p]) begin
				if (rx_exp[p].size() == 0) begin
					$display("port %0d returned a word that no read asked for", p);
					stop_on_fail();
				end else begin
					check_data(rdata[p], rx_exp[p].pop_front(),
						$sformatf("port %0d read data", p));
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		addr_t a;
		addr_t b;
		addr_t rd_list [$];
		addr_t ovf_addr [$];
		int i;
		int p;
		int sva_fails;

		clock_bus = 1'b0;
		reset     = 1'b0;
		lfsr_q    = 16'd9767;
		for (p = 0; p < 2; p++) begin
			req[p]      = 1'b0;
			rw[p]       = 1'b0;
			addr[p]     = '0;
			write_en[p] = 1'b0;
			wdata[p]    = '0;
			read_ack[p] = 1'b0;
			exc_exp[p]  = '0;
		end
		repeat (5) @(posedge clock_bus);
		@(negedge clock_bus);
		reset = 1'b1;

		// reset state
		for (p = 0; p < 2; p++) begin
			check_flag(ready_req[p], 1'b1, "ready_req after reset");
			check_flag(ready_write[p], 1'b1, "ready_write after reset");
			check_flag(ready_read[p], 1'b0, "ready_read after reset");
			check_exc(exc[p], '0, "exception after reset");
		end

		// port 0 write then read of the same word
		a = fresh_addr();
		push_word(0, data_t'(rand_bits(32)));
		issue_req(0, 1'b1, a);
		read_back(0, a);
		check_flag(ready_read[0], 1'b0, "port 0 ready_read after ack");

		// both ports write at once, then read each other's words
		for (p = 0; p < 2; p++) begin
			for (i = 0; i < 8; i++) begin
				wr_addr[p].push_back(fresh_addr());
				wr_data[p].push_back(data_t'(rand_bits(32)));
			end
		end
		fork
			write_burst(0);
			write_burst(1);
		join
		wait_high(0, LVL_REQ, "ready_req after write burst");
		wait_high(1, LVL_REQ, "ready_req after write burst");
		fork
			cross_read(0, 1);
			cross_read(1, 0);
		join

		// 18 reads on port 1, the 17th stalls on a full rx fifo
		rd_list = {wr_addr[0], wr_addr[1]};
		for (i = 0; i < 17; i++) begin
			issue_req(1, 1'b0, rd_list[i % 16]);
		end
		repeat (8) begin
			@(negedge clock_bus);
			check_flag(ready_req[1], 1'b0, "port 1 ready_req with rx full");
			check_flag(ready_read[1], 1'b1, "port 1 ready_read with rx full");
		end
		fork
			issue_req(1, 1'b0, rd_list[17 % 16]);
			repeat (18) ack_word(1);
		join
		check_flag(ready_read[1], 1'b0, "port 1 ready_read after drain");
		check_exc(exc[1], exc_exp[1], "port 1 exception after drain");

		// 17 pushes into port 0, last one dropped
		for (i = 0; i < DEPTH + 1; i++) begin
			check_flag(ready_write[0], tx_q[0].size() < DEPTH, "port 0 ready_write");
			pulse_write(0, data_t'(rand_bits(32)));
		end
		check_exc(exc[0], exc_exp[0], "port 0 exception after tx overflow");
		for (i = 0; i < DEPTH; i++) begin
			a = fresh_addr();
			ovf_addr.push_back(a);
			issue_req(0, 1'b1, a);
		end
		for (i = 0; i < DEPTH; i++) begin
			read_back(0, ovf_addr[i]);
		end
		check_flag(ready_write[0], 1'b1, "port 0 ready_write after drain");

		// rx underflow on port 1
		check_flag(ready_read[1], 1'b0, "port 1 ready_read before underflow");
		pulse_ack(1);
		check_exc(exc[1], exc_exp[1], "port 1 exception after rx underflow");

		// second req while pending is dropped
		a = rd_list[0];
		b = rd_list[1];
		push_word(1, data_t'(rand_bits(32)));
		push_word(1, data_t'(rand_bits(32)));
		issue_req(1, 1'b1, a);
		check_flag(ready_req[1], 1'b0, "port 1 ready_req after capture");
		exc_exp[1][`L2L1_EXC_REQ_OVR] = 1'b1;
		pulse_req(1, 1'b1, b);
		check_exc(exc[1], exc_exp[1], "port 1 exception after request overrun");
		read_back(1, a);
		read_back(1, b);

		check_exc(exc[0], exc_exp[0], "port 0 final exception");
		check_exc(exc[1], exc_exp[1], "port 1 final exception");
		sva_fails = l2l1_top_inst.l2_arbiter_inst.arb_sva_inst.fail_cnt
			+ l2l1_top_inst.buf0_inst.buf_sva_inst.fail_cnt
			+ l2l1_top_inst.buf1_inst.buf_sva_inst.fail_cnt;
		if (sva_fails != 0) begin
			$display("%0d bound assertions failed during the run", sva_fails);
			stop_on_fail();
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* hw/l2_arbiter.sv */
`default_nettype none

`include "l2l1_params.svh"

module l2_arbiter import l2l1_pkg::*; (
	input  logic clock_bus_i,
	input  logic reset_i,

	l2_port_if.arbiter p0,
	l2_port_if.arbiter p1,

	// store side
	output logic        st_we_o,
	output logic        st_re_o,
	output store_addr_t st_addr_o,
	output data_t       st_wdata_o,
	input  data_t       st_rdata_i
);

	arb_state_t state_q;

	// round-robin bit, 0 means port 0 first
	logic prio_q;
	// port being served
	logic sel_q;
	store_addr_t addr_q;

	logic q0, q1;
	logic pick, pick_rw;
	addr_t pick_addr;
	logic grant_any;

	// ---------------------------------------------------------------------------
	// qualification and pick
	// ---------------------------------------------------------------------------

	// write needs tx data, read needs rx room
	assign q0 = p0.req_pend && (p0.req_rw ? p0.tx_avail : p0.rx_space);
	assign q1 = p1.req_pend && (p1.req_rw ? p1.tx_avail : p1.rx_space);

	// favoured port if it qualifies, else the other
	assign pick      = prio_q ? q1 : !q0;
	assign pick_rw   = pick ? p1.req_rw : p0.req_rw;
	assign pick_addr = pick ? p1.req_addr : p0.req_addr;
	assign grant_any = (state_q == ARB_IDLE) && (q0 || q1);

	// ---------------------------------------------------------------------------
	// fsm
	// ---------------------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state_q <= ARB_IDLE;
			prio_q  <= 1'b0;
			sel_q   <= 1'b0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (grant_any) begin
						state_q <= pick_rw ? ARB_WRITE : ARB_READ;
						sel_q   <= pick;
						prio_q  <= ~prio_q;
					end
				end
				ARB_WRITE: state_q <= ARB_IDLE;
				ARB_READ:  state_q <= ARB_RESP;
				ARB_RESP:  state_q <= ARB_IDLE;
				default:   state_q <= ARB_IDLE;
			endcase
		end
	end

	// buffer may reload its request once grant lands
	always_ff @(posedge clock_bus_i) begin
		if (grant_any) begin
			addr_q <= pick_addr[`L2L1_STORE_AW-1:0];
		end
	end

	// ---------------------------------------------------------------------------
	// port strobes
	// ---------------------------------------------------------------------------
	assign p0.grant   = grant_any && !pick;
	assign p1.grant   = grant_any && pick;
	assign p0.tx_pop  = (state_q == ARB_WRITE) && !sel_q;
	assign p1.tx_pop  = (state_q == ARB_WRITE) && sel_q;
	// store data is valid in the cycle after st_re
	assign p0.rx_push = (state_q == ARB_RESP) && !sel_q;
	assign p1.rx_push = (state_q == ARB_RESP) && sel_q;
	assign p0.rx_data = st_rdata_i;
	assign p1.rx_data = st_rdata_i;

	// store drive
	assign st_we_o    = (state_q == ARB_WRITE);
	assign st_re_o    = (state_q == ARB_READ);
	assign st_addr_o  = addr_q;
	assign st_wdata_o = sel_q ? p1.tx_head : p0.tx_head;

endmodule

`default_nettype wire

/* hw/l2_port_if.sv */
`default_nettype none

interface l2_port_if import l2l1_pkg::*; ();

	// request held by the buffer
	logic  req_pend;
	logic  req_rw;
	addr_t req_addr;

	// tx fifo head and status
	data_t tx_head;
	logic  tx_avail;
	// rx fifo has room for one more word
	logic  rx_space;

	// arbiter strobes
	logic  grant;
	logic  tx_pop;
	logic  rx_push;
	data_t rx_data;

	modport buffer (
		output req_pend, req_rw, req_addr, tx_head, tx_avail, rx_space,
		input  grant, tx_pop, rx_push, rx_data
	);

	modport arbiter (
		input  req_pend, req_rw, req_addr, tx_head, tx_avail, rx_space,
		output grant, tx_pop, rx_push, rx_data
	);

endinterface

`default_nettype wire

/* hw/l2_store.sv */
`default_nettype none

module l2_store import l2l1_pkg::*; (
	input  logic        clock_bus_i,
	input  logic        we_i,
	input  logic        re_i,
	input  store_addr_t addr_i,
	input  data_t       wdata_i,
	output data_t       rdata_o
);

	localparam int WORDS = 1 << $bits(store_addr_t);

	// shared l2 words, contents undefined until written
	data_t mem [WORDS];

	// ---------------------------------------------------------------------------
	// write port
	// ---------------------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

	// ---------------------------------------------------------------------------
	// registered read, data one cycle after re_i
	// ---------------------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (re_i) begin
			rdata_o <= mem[addr_i];
		end
	end

endmodule

`default_nettype wire

/* hw/l2l1_pkg.sv */
`default_nettype none

`include "l2l1_params.svh"

package l2l1_pkg;

	// ------------------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------------------

	// controller request address
	typedef logic [`L2L1_ADDR_W-1:0] addr_t;

	// one data word
	typedef logic [`L2L1_DATA_W-1:0] data_t;

	// sticky exception flags
	typedef logic [3:0] exc_t;

	// fifo occupancy, one extra bit so a full fifo fits
	typedef logic [$clog2(`L2L1_BUF_DEPTH):0] cnt_t;

	// word address inside the l2 store
	typedef logic [`L2L1_STORE_AW-1:0] store_addr_t;

	// ------------------------------------------------------------------------
	// arbiter fsm
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_WRITE = 2'd1,
		ARB_READ  = 2'd2,
		ARB_RESP  = 2'd3
	} arb_state_t;

endpackage

`default_nettype wire

/* hw/l2l1_top.sv */
`default_nettype none

`include "l2l1_params.svh"

module l2l1_top import l2l1_pkg::*; (
	input  logic clock_bus_i,
	input  logic reset_i,

	// l1 controller 0
	input  logic  req_0_i,
	input  logic  rw_0_i,
	input  addr_t addr_0_i,
	input  logic  write_en_0_i,
	input  data_t data_0_i,
	input  logic  read_ack_0_i,
	output logic  ready_req_0_o,
	output logic  ready_write_0_o,
	output logic  ready_read_0_o,
	output data_t data_0_o,
	output exc_t  exception_0_o,

	// l1 controller 1
	input  logic  req_1_i,
	input  logic  rw_1_i,
	input  addr_t addr_1_i,
	input  logic  write_en_1_i,
	input  data_t data_1_i,
	input  logic  read_ack_1_i,
	output logic  ready_req_1_o,
	output logic  ready_write_1_o,
	output logic  ready_read_1_o,
	output data_t data_1_o,
	output exc_t  exception_1_o
);

	l2_port_if port0_if ();
	l2_port_if port1_if ();

	// arbiter to store
	logic        st_we, st_re;
	store_addr_t st_addr;
	data_t       st_wdata, st_rdata;

	// ---------------------------------------------------------------------------
	// per-port buffers
	// ---------------------------------------------------------------------------
	txrx_buffer buf0_inst (
		.clock_bus_i  (clock_bus_i),
		.reset_i      (reset_i),
		.req_i        (req_0_i),
		.rw_i         (rw_0_i),
		.addr_i       (addr_0_i),
		.write_en_i   (write_en_0_i),
		.data_i       (data_0_i),
		.read_ack_i   (read_ack_0_i),
		.ready_req_o  (ready_req_0_o),
		.ready_write_o(ready_write_0_o),
		.ready_read_o (ready_read_0_o),
		.data_o       (data_0_o),
		.exception_o  (exception_0_o),
		.port         (port0_if.buffer)
	);

	txrx_buffer buf1_inst (
		.clock_bus_i  (clock_bus_i),
		.reset_i      (reset_i),
		.req_i        (req_1_i),
		.rw_i         (rw_1_i),
		.addr_i       (addr_1_i),
		.write_en_i   (write_en_1_i),
		.data_i       (data_1_i),
		.read_ack_i   (read_ack_1_i),
		.ready_req_o  (ready_req_1_o),
		.ready_write_o(ready_write_1_o),
		.ready_read_o (ready_read_1_o),
		.data_o       (data_1_o),
		.exception_o  (exception_1_o),
		.port         (port1_if.buffer)
	);

	// ---------------------------------------------------------------------------
	// shared arbiter and l2 store
	// ---------------------------------------------------------------------------
	l2_arbiter l2_arbiter_inst (
		.clock_bus_i(clock_bus_i),
		.reset_i    (reset_i),
		.p0         (port0_if.arbiter),
		.p1         (port1_if.arbiter),
		.st_we_o    (st_we),
		.st_re_o    (st_re),
		.st_addr_o  (st_addr),
		.st_wdata_o (st_wdata),
		.st_rdata_i (st_rdata)
	);

	l2_store l2_store_inst (
		.clock_bus_i(clock_bus_i),
		.we_i       (st_we),
		.re_i       (st_re),
		.addr_i     (st_addr),
		.wdata_i    (st_wdata),
		.rdata_o    (st_rdata)
	);

endmodule

`default_nettype wire

/* hw/txrx_buffer.sv */
`default_nettype none

`include "l2l1_params.svh"

module txrx_buffer import l2l1_pkg::*; (
	input  logic clock_bus_i,
	input  logic reset_i,

	// controller side
	input  logic  req_i,
	input  logic  rw_i,
	input  addr_t addr_i,
	input  logic  write_en_i,
	input  data_t data_i,
	input  logic  read_ack_i,
	output logic  ready_req_o,
	output logic  ready_write_o,
	output logic  ready_read_o,
	output data_t data_o,
	output exc_t  exception_o,

	// arbiter side
	l2_port_if.buffer port
);

	localparam int PTR_W = $clog2(`L2L1_BUF_DEPTH);

	// storage, no reset
	data_t tx_mem [`L2L1_BUF_DEPTH];
	data_t rx_mem [`L2L1_BUF_DEPTH];

	logic [PTR_W-1:0] tx_wptr, tx_rptr;
	logic [PTR_W-1:0] rx_wptr, rx_rptr;
	cnt_t tx_cnt, rx_cnt;

	// pending request
	logic  req_pend_q;
	logic  req_rw_q;
	addr_t req_addr_q;

	exc_t exc_q;

	logic tx_full, tx_empty, rx_full, rx_empty;
	logic tx_push, rx_pop, req_take;

	// ---------------------------------------------------------------------------
	// status and qualified strobes
	// ---------------------------------------------------------------------------
	assign tx_full  = (tx_cnt == cnt_t'(`L2L1_BUF_DEPTH));
	assign tx_empty = (tx_cnt == '0);
	assign rx_full  = (rx_cnt == cnt_t'(`L2L1_BUF_DEPTH));
	assign rx_empty = (rx_cnt == '0);

	// a full tx drops the word, an empty rx ignores the ack
	assign tx_push  = write_en_i && !tx_full;
	assign rx_pop   = read_ack_i && !rx_empty;
	// only one request may be held
	assign req_take = req_i && !req_pend_q;

	// controller outputs
	assign ready_req_o   = !req_pend_q;
	assign ready_write_o = !tx_full;
	assign ready_read_o  = !rx_empty;
	assign data_o        = rx_mem[rx_rptr];
	assign exception_o   = exc_q;

	// arbiter view
	assign port.req_pend = req_pend_q;
	assign port.req_rw   = req_rw_q;
	assign port.req_addr = req_addr_q;
	assign port.tx_head  = tx_mem[tx_rptr];
	assign port.tx_avail = !tx_empty;
	assign port.rx_space = !rx_full;

	// ---------------------------------------------------------------------------
	// payload writes
	// ---------------------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (tx_push) begin
			tx_mem[tx_wptr] <= data_i;
		end
		// arbiter only pushes when space was seen at grant
		if (port.rx_push) begin
			rx_mem[rx_wptr] <= port.rx_data;
		end
		if (req_take) begin
			req_rw_q   <= rw_i;
			req_addr_q <= addr_i;
		end
	end

	// ---------------------------------------------------------------------------
	// pointers, counts, request flag, exceptions
	// ---------------------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			tx_wptr    <= '0;
			tx_rptr    <= '0;
			tx_cnt     <= '0;
			rx_wptr    <= '0;
			rx_rptr    <= '0;
			rx_cnt     <= '0;
			req_pend_q <= 1'b0;
			exc_q      <= '0;
		end else begin
			// tx side, filled by controller, drained by arbiter
			if (tx_push) begin
				tx_wptr <= tx_wptr + 1'b1;
			end
			if (port.tx_pop) begin
				tx_rptr <= tx_rptr + 1'b1;
			end
			tx_cnt <= tx_cnt + cnt_t'(tx_push) - cnt_t'(port.tx_pop);

			// rx side, filled by arbiter, drained by controller
			if (port.rx_push) begin
				rx_wptr <= rx_wptr + 1'b1;
			end
			if (rx_pop) begin
				rx_rptr <= rx_rptr + 1'b1;
			end
			rx_cnt <= rx_cnt + cnt_t'(port.rx_push) - cnt_t'(rx_pop);

			// grant only comes while pending, so no clash with take
			if (req_take) begin
				req_pend_q <= 1'b1;
			end else if (port.grant) begin
				req_pend_q <= 1'b0;
			end

			// sticky flags
			if (write_en_i && tx_full) begin
				exc_q[`L2L1_EXC_TX_OVF] <= 1'b1;
			end
			if (read_ack_i && rx_empty) begin
				exc_q[`L2L1_EXC_RX_UDF] <= 1'b1;
			end
			if (req_i && req_pend_q) begin
				exc_q[`L2L1_EXC_REQ_OVR] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* include/l2l1_params.svh */
`ifndef L2L1_PARAMS_SVH
`define L2L1_PARAMS_SVH

// ---------------------------------------------------------------------------
// buffer and bus sizing
// ---------------------------------------------------------------------------

// words per tx and rx fifo
`define L2L1_BUF_DEPTH 16

// request address and data word widths
`define L2L1_ADDR_W 24
`define L2L1_DATA_W 32

// low address bits that index the l2 store
`define L2L1_STORE_AW 8

// ---------------------------------------------------------------------------
// exception vector bit positions, bit 3 reserved
// ---------------------------------------------------------------------------
`define L2L1_EXC_TX_OVF 0
`define L2L1_EXC_RX_UDF 1
`define L2L1_EXC_REQ_OVR 2

`endif

/* src.f */
+incdir+include
hw/l2l1_pkg.sv
hw/l2_port_if.sv
hw/txrx_buffer.sv
hw/l2_arbiter.sv
hw/l2_store.sv
hw/l2l1_top.sv
dv/l2l1_sva.sv
dv/l2l1_tb.sv
